// File: logic/qm_macros.svh
`ifndef QM_MACROS_SVH
`define QM_MACROS_SVH

// Queue table geometry.
`define QM_NB_QUEUES        16
`define QM_QUEUE_ID_WIDTH   4

// Host ring and descriptor fields.
`define QM_RING_AWIDTH      12
`define QM_PKT_SIZE_WIDTH   7
`define QM_META_WIDTH       8
`define QM_BUF_ADDR_WIDTH   32
`define QM_CNT_WIDTH        32

// FIFO sizing.
`define QM_IN_FIFO_DEPTH    16
`define QM_OUT_FIFO_DEPTH   16
`define QM_OUT_AFULL_LEVEL  8

`endif

// File: logic/qm_pkg.sv
`include "qm_macros.svh"

package qm_pkg;

    typedef logic [`QM_QUEUE_ID_WIDTH-1:0] queue_id_t;

    // Ring pointers; the size needs one more bit to hold a full ring.
    typedef logic [`QM_RING_AWIDTH-1:0] ring_ptr_t;
    typedef logic [`QM_RING_AWIDTH:0]   ring_size_t;

    // Packet size, counted in flits.
    typedef logic [`QM_PKT_SIZE_WIDTH-1:0] pkt_size_t;
    typedef logic [`QM_META_WIDTH-1:0]     meta_t;
    typedef logic [`QM_BUF_ADDR_WIDTH-1:0] buf_addr_t;
    typedef logic [`QM_CNT_WIDTH-1:0]      cnt_t;

    // Table addressed by a host write.
    typedef enum logic [1:0] {
        TABLE_HEAD = 2'd0,
        TABLE_TAIL = 2'd1,
        TABLE_ADDR = 2'd2
    } table_sel_t;

endpackage

// File: logic/qm_if.sv
`timescale 1ns/1ps
`include "qm_macros.svh"

// Internal port of one queue table.
interface table_port_if #(
    parameter int DWIDTH = `QM_BUF_ADDR_WIDTH
);
    import qm_pkg::*;

    queue_id_t         addr;
    logic              rd_en;
    logic              wr_en;
    logic [DWIDTH-1:0] wr_data;
    logic [DWIDTH-1:0] rd_data;

    modport owner (output addr, output rd_en, output wr_en, output wr_data, input rd_data);
    modport mem (input addr, input rd_en, input wr_en, input wr_data, output rd_data);

endinterface

// Queue state fetched for one descriptor; valid is a single-cycle pulse.
interface fetched_state_if;
    import qm_pkg::*;

    logic      valid;
    queue_id_t queue;
    ring_ptr_t head;
    ring_ptr_t tail;
    buf_addr_t buf_addr;
    pkt_size_t pkt_size;
    meta_t     meta;
    logic      pass_through;

    modport src (
        output valid, output queue, output head, output tail,
        output buf_addr, output pkt_size, output meta, output pass_through
    );
    modport dst (
        input valid, input queue, input head, input tail,
        input buf_addr, input pkt_size, input meta, input pass_through
    );

endinterface

// File: logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH       = 8,
    parameter int DEPTH       = 16,
    parameter int AFULL_LEVEL = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             wr_valid,
    output logic             wr_ready,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_valid,
    input  logic             rd_ready,
    output logic             almost_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign wr_ready    = (count != CNT_W'(DEPTH));
    assign rd_valid    = (count != '0);
    assign almost_full = (count > CNT_W'(AFULL_LEVEL));
    assign push        = wr_valid & wr_ready;
    assign pop         = rd_valid & rd_ready;

    // Show-ahead output, the head entry is always presented.
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: logic/queue_table.sv
`timescale 1ns/1ps
`include "qm_macros.svh"

module queue_table #(
    parameter int DWIDTH = 32
) (
    input  logic              clk,
    table_port_if.mem         int_port,
    input  logic              host_wr_en,
    input  qm_pkg::queue_id_t host_addr,
    input  logic [DWIDTH-1:0] host_wr_data
);

    import qm_pkg::*;

    logic [DWIDTH-1:0] rows [`QM_NB_QUEUES];
    queue_id_t         addr_r;

    // Host writes land after the internal one, so the host wins a collision.
    always_ff @(posedge clk) begin
        if (int_port.wr_en) begin
            rows[int_port.addr] <= int_port.wr_data;
        end
        if (host_wr_en) begin
            rows[host_addr] <= host_wr_data;
        end
    end

    // Address register then output register.
    always_ff @(posedge clk) begin
        if (int_port.rd_en) begin
            addr_r <= int_port.addr;
        end
        int_port.rd_data <= rows[addr_r];
    end

endmodule

// File: logic/state_fetch.sv
`timescale 1ns/1ps

module state_fetch (
    input  logic              clk,
    input  logic              rst,
    input  qm_pkg::queue_id_t in_queue_id,
    input  qm_pkg::pkt_size_t in_size,
    input  logic              in_pass_through,
    input  qm_pkg::meta_t     in_meta,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic              out_almost_full,
    input  logic              tail_wr_en,
    input  qm_pkg::queue_id_t wr_queue,
    input  qm_pkg::ring_ptr_t new_tail,
    input  logic              host_head_wr_en,
    input  qm_pkg::queue_id_t host_head_queue,
    input  qm_pkg::ring_ptr_t host_head_data,
    table_port_if.owner       head_port,
    table_port_if.owner       tail_port,
    table_port_if.owner       addr_port,
    fetched_state_if.src      fetched
);

    import qm_pkg::*;

    logic       accept;
    logic       rd_en;
    queue_id_t  rd_queue;
    logic       head_bypass;
    logic [1:0] vld_d;
    logic [1:0] bypass_d;
    queue_id_t  queue_d [2];
    ring_ptr_t  host_head_d [2];
    pkt_size_t  size_d [3];
    meta_t      meta_d [3];
    logic [2:0] pass_d;

    // A fetched state that updates its tail means a write-back next cycle,
    // and the tail port cannot read then.
    assign in_ready = !out_almost_full & !(vld_d[1] & !pass_d[0]);
    assign accept   = in_valid & in_ready;

    // Host head write racing the head read of the same queue.
    assign head_bypass = host_head_wr_en & (host_head_queue == rd_queue);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en    <= 1'b0;
            vld_d    <= '0;
            bypass_d <= '0;
        end else begin
            rd_en    <= accept;
            vld_d    <= {vld_d[0], rd_en};
            bypass_d <= {bypass_d[0], rd_en & head_bypass};
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Descriptor delay line, aligned with the two-cycle table read.
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_queue  <= in_queue_id;
            size_d[2] <= in_size;
            meta_d[2] <= in_meta;
            pass_d[2] <= in_pass_through;
        end
        size_d[1]      <= size_d[2];
        size_d[0]      <= size_d[1];
        meta_d[1]      <= meta_d[2];
        meta_d[0]      <= meta_d[1];
        pass_d[1:0]    <= pass_d[2:1];
        queue_d[0]     <= rd_queue;
        queue_d[1]     <= queue_d[0];
        host_head_d[0] <= host_head_data;
        host_head_d[1] <= host_head_d[0];
    end

    ///////////////////////////////////////////////////////////////////////
    // Table requests.
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        head_port.addr    = rd_queue;
        head_port.rd_en   = rd_en & !head_bypass;
        head_port.wr_en   = 1'b0;
        head_port.wr_data = '0;

        addr_port.addr    = rd_queue;
        addr_port.rd_en   = rd_en;
        addr_port.wr_en   = 1'b0;
        addr_port.wr_data = '0;

        // Reads take the port; the write-back only uses idle cycles.
        tail_port.rd_en   = rd_en;
        tail_port.wr_en   = tail_wr_en & !rd_en;
        tail_port.addr    = rd_en ? rd_queue : wr_queue;
        tail_port.wr_data = new_tail;
    end

    assign fetched.valid        = vld_d[1];
    assign fetched.queue        = queue_d[1];
    assign fetched.head         = bypass_d[1] ? host_head_d[1] : head_port.rd_data;
    assign fetched.tail         = tail_port.rd_data;
    assign fetched.buf_addr     = addr_port.rd_data;
    assign fetched.pkt_size     = size_d[0];
    assign fetched.meta         = meta_d[0];
    assign fetched.pass_through = pass_d[0];

endmodule

// File: logic/ring_update.sv
`timescale 1ns/1ps

module ring_update (
    input  logic               clk,
    input  logic               rst,
    input  qm_pkg::ring_size_t rb_size,
    fetched_state_if.dst       fetched,
    output logic               tail_wr_en,
    output qm_pkg::queue_id_t  wr_queue,
    output qm_pkg::ring_ptr_t  new_tail,
    output qm_pkg::ring_ptr_t  q_head,
    output qm_pkg::ring_ptr_t  q_tail,
    output qm_pkg::buf_addr_t  q_buf_addr,
    output logic               q_drop,
    output qm_pkg::meta_t      q_meta,
    output logic               q_valid,
    output qm_pkg::cnt_t       full_cnt
);

    import qm_pkg::*;

    // Index 1 is the decision of the previous cycle, index 0 the one before.
    logic [1:0] fwd_valid;
    queue_id_t  fwd_queue [2];
    ring_ptr_t  fwd_tail [2];

    ring_ptr_t rb_mask;
    ring_ptr_t cur_tail;
    ring_ptr_t free_slots;
    ring_ptr_t adv_tail;
    ring_ptr_t next_tail;
    logic      full;
    logic      drop;
    logic      advance;

    // Ring sizes are powers of two.
    always_ff @(posedge clk) begin
        rb_mask <= ring_ptr_t'(rb_size - 1'b1);
    end

    ///////////////////////////////////////////////////////////////////////
    // Drop and advance decision.
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        // Tails written in the last two cycles are not yet in the table read.
        if (fwd_valid[1] && (fwd_queue[1] == fetched.queue)) begin
            cur_tail = fwd_tail[1];
        end else if (fwd_valid[0] && (fwd_queue[0] == fetched.queue)) begin
            cur_tail = fwd_tail[0];
        end else begin
            cur_tail = fetched.tail;
        end

        // One slot stays empty to tell a full ring from an empty one.
        free_slots = (fetched.head - cur_tail - 1'b1) & rb_mask;
        full       = (free_slots < ring_ptr_t'(fetched.pkt_size)) & !fetched.pass_through;
        drop       = full | (fetched.buf_addr == '0);
        advance    = !drop & !fetched.pass_through;
        adv_tail   = (cur_tail + ring_ptr_t'(fetched.pkt_size)) & rb_mask;
        next_tail  = advance ? adv_tail : cur_tail;
    end

    always_ff @(posedge clk) begin
        if (fetched.valid) begin
            q_head       <= fetched.head;
            q_tail       <= cur_tail;
            q_buf_addr   <= fetched.buf_addr;
            q_drop       <= drop;
            q_meta       <= fetched.meta;
            wr_queue     <= fetched.queue;
            new_tail     <= next_tail;
            fwd_queue[1] <= fetched.queue;
            fwd_tail[1]  <= next_tail;
        end
        fwd_queue[0] <= fwd_queue[1];
        fwd_tail[0]  <= fwd_tail[1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_valid    <= 1'b0;
            tail_wr_en <= 1'b0;
            fwd_valid  <= '0;
            full_cnt   <= '0;
        end else begin
            q_valid    <= fetched.valid;
            tail_wr_en <= fetched.valid & advance;
            fwd_valid  <= {fetched.valid, fwd_valid[1]};
            if (fetched.valid && full) begin
                full_cnt <= full_cnt + 1'b1;
            end
        end
    end

endmodule

// File: logic/queue_manager.sv
`timescale 1ns/1ps
`include "qm_macros.svh"

module queue_manager (
    input  logic               clk,
    input  logic               rst,
    input  qm_pkg::queue_id_t  in_queue_id,
    input  qm_pkg::pkt_size_t  in_size,
    input  logic               in_pass_through,
    input  qm_pkg::meta_t      in_meta,
    input  logic               in_valid,
    output logic               in_ready,
    output qm_pkg::ring_ptr_t  out_head,
    output qm_pkg::ring_ptr_t  out_tail,
    output qm_pkg::buf_addr_t  out_buf_addr,
    output logic               out_drop,
    output qm_pkg::meta_t      out_meta,
    output logic               out_valid,
    input  logic               out_ready,
    input  logic               cfg_wr_en,
    input  qm_pkg::table_sel_t cfg_sel,
    input  qm_pkg::queue_id_t  cfg_queue,
    input  qm_pkg::buf_addr_t  cfg_data,
    input  qm_pkg::ring_size_t rb_size,
    output qm_pkg::cnt_t       full_cnt
);

    import qm_pkg::*;

    localparam int IN_WIDTH  = $bits(queue_id_t) + $bits(pkt_size_t) + 1 + $bits(meta_t);
    localparam int OUT_WIDTH = 2 * $bits(ring_ptr_t) + $bits(buf_addr_t) + 1 + $bits(meta_t);

    // Input FIFO read side.
    queue_id_t fifo_queue_id;
    pkt_size_t fifo_size;
    logic      fifo_pass_through;
    meta_t     fifo_meta;
    logic      fifo_valid;
    logic      fifo_ready;
    logic      out_almost_full;

    // Tail write-back.
    logic      tail_wr_en;
    queue_id_t wr_queue;
    ring_ptr_t new_tail;

    // Output FIFO write side.
    ring_ptr_t q_head;
    ring_ptr_t q_tail;
    buf_addr_t q_buf_addr;
    logic      q_drop;
    meta_t     q_meta;
    logic      q_valid;

    // Host write decode.
    logic      head_wr_en;
    logic      tail_wr_host;
    logic      addr_wr_en;
    ring_ptr_t cfg_ptr;

    assign head_wr_en   = cfg_wr_en & (cfg_sel == TABLE_HEAD);
    assign tail_wr_host = cfg_wr_en & (cfg_sel == TABLE_TAIL);
    assign addr_wr_en   = cfg_wr_en & (cfg_sel == TABLE_ADDR);
    assign cfg_ptr      = cfg_data[`QM_RING_AWIDTH-1:0];

    table_port_if #(.DWIDTH(`QM_RING_AWIDTH))    head_if ();
    table_port_if #(.DWIDTH(`QM_RING_AWIDTH))    tail_if ();
    table_port_if #(.DWIDTH(`QM_BUF_ADDR_WIDTH)) addr_if ();
    fetched_state_if                             fetched_if ();

    ///////////////////////////////////////////////////////////////////////
    // Pipeline stages.
    ///////////////////////////////////////////////////////////////////////

    sync_fifo #(
        .WIDTH       (IN_WIDTH),
        .DEPTH       (`QM_IN_FIFO_DEPTH),
        .AFULL_LEVEL (`QM_IN_FIFO_DEPTH - 1)
    ) in_fifo (
        .clk         (clk),
        .rst         (rst),
        .wr_data     ({in_queue_id, in_size, in_pass_through, in_meta}),
        .wr_valid    (in_valid),
        .wr_ready    (in_ready),
        .rd_data     ({fifo_queue_id, fifo_size, fifo_pass_through, fifo_meta}),
        .rd_valid    (fifo_valid),
        .rd_ready    (fifo_ready),
        .almost_full ()
    );

    state_fetch u_state_fetch (
        .clk             (clk),
        .rst             (rst),
        .in_queue_id     (fifo_queue_id),
        .in_size         (fifo_size),
        .in_pass_through (fifo_pass_through),
        .in_meta         (fifo_meta),
        .in_valid        (fifo_valid),
        .in_ready        (fifo_ready),
        .out_almost_full (out_almost_full),
        .tail_wr_en      (tail_wr_en),
        .wr_queue        (wr_queue),
        .new_tail        (new_tail),
        .host_head_wr_en (head_wr_en),
        .host_head_queue (cfg_queue),
        .host_head_data  (cfg_ptr),
        .head_port       (head_if),
        .tail_port       (tail_if),
        .addr_port       (addr_if),
        .fetched         (fetched_if)
    );

    ring_update u_ring_update (
        .clk        (clk),
        .rst        (rst),
        .rb_size    (rb_size),
        .fetched    (fetched_if),
        .tail_wr_en (tail_wr_en),
        .wr_queue   (wr_queue),
        .new_tail   (new_tail),
        .q_head     (q_head),
        .q_tail     (q_tail),
        .q_buf_addr (q_buf_addr),
        .q_drop     (q_drop),
        .q_meta     (q_meta),
        .q_valid    (q_valid),
        .full_cnt   (full_cnt)
    );

    // Almost-full leaves room for everything in flight, so wr_ready is not needed.
    sync_fifo #(
        .WIDTH       (OUT_WIDTH),
        .DEPTH       (`QM_OUT_FIFO_DEPTH),
        .AFULL_LEVEL (`QM_OUT_AFULL_LEVEL)
    ) out_fifo (
        .clk         (clk),
        .rst         (rst),
        .wr_data     ({q_head, q_tail, q_buf_addr, q_drop, q_meta}),
        .wr_valid    (q_valid),
        .wr_ready    (),
        .rd_data     ({out_head, out_tail, out_buf_addr, out_drop, out_meta}),
        .rd_valid    (out_valid),
        .rd_ready    (out_ready),
        .almost_full (out_almost_full)
    );

    ///////////////////////////////////////////////////////////////////////
    // Queue tables.
    ///////////////////////////////////////////////////////////////////////

    queue_table #(.DWIDTH(`QM_RING_AWIDTH)) head_table (
        .clk          (clk),
        .int_port     (head_if),
        .host_wr_en   (head_wr_en),
        .host_addr    (cfg_queue),
        .host_wr_data (cfg_ptr)
    );

    queue_table #(.DWIDTH(`QM_RING_AWIDTH)) tail_table (
        .clk          (clk),
        .int_port     (tail_if),
        .host_wr_en   (tail_wr_host),
        .host_addr    (cfg_queue),
        .host_wr_data (cfg_ptr)
    );

    queue_table #(.DWIDTH(`QM_BUF_ADDR_WIDTH)) addr_table (
        .clk          (clk),
        .int_port     (addr_if),
        .host_wr_en   (addr_wr_en),
        .host_addr    (cfg_queue),
        .host_wr_data (cfg_data)
    );

endmodule

// File: sim/tb_queue_manager.sv
`timescale 1ns/1ps
`include "qm_macros.svh"

module tb_queue_manager;

    import qm_pkg::*;

    typedef enum logic [1:0] {OP_PKT, OP_CFG, OP_HOLD} op_t;

    typedef struct packed {
        op_t        op;
        queue_id_t  queue;
        pkt_size_t  size;
        logic       pt;
        table_sel_t sel;
        buf_addr_t  data;
        logic [1:0] expect_drop;
    } stim_t;

    localparam logic [1:0] EXP_ANY  = 2'd0;
    localparam logic [1:0] EXP_KEEP = 2'd1;
    localparam logic [1:0] EXP_DROP = 2'd2;
    localparam ring_ptr_t  RING_MASK = 12'd63;

    logic       clk = 1'b0;
    logic       rst;
    queue_id_t  in_queue_id;
    pkt_size_t  in_size;
    logic       in_pass_through;
    meta_t      in_meta;
    logic       in_valid;
    logic       in_ready;
    ring_ptr_t  out_head;
    ring_ptr_t  out_tail;
    buf_addr_t  out_buf_addr;
    logic       out_drop;
    meta_t      out_meta;
    logic       out_valid;
    logic       out_ready = 1'b1;
    logic       cfg_wr_en;
    table_sel_t cfg_sel;
    queue_id_t  cfg_queue;
    buf_addr_t  cfg_data;
    ring_size_t rb_size;
    cnt_t       full_cnt;

    // Stimulus table and its reference model state.
    stim_t       stim_tbl [128];
    int          tbl_len;
    logic        table_ready = 1'b0;
    logic [15:0] stim_lfsr;
    ring_ptr_t   m_head [`QM_NB_QUEUES];
    ring_ptr_t   m_tail [`QM_NB_QUEUES];
    buf_addr_t   m_addr [`QM_NB_QUEUES];
    cnt_t        m_full;

    // Expected outputs in order; written at exp_wr, consumed at exp_rd.
    ring_ptr_t exp_head [256];
    ring_ptr_t exp_tail [256];
    buf_addr_t exp_addr [256];
    logic      exp_drop [256];
    meta_t     exp_meta [256];
    int        exp_wr;
    int        exp_rd = 0;

    // Output back-pressure control.
    int          hold_end;
    logic        random_ready;
    int          cycle = 0;
    logic        holding = 1'b0;
    logic        saw_stall = 1'b0;
    logic [15:0] ready_lfsr = 16'd47;

    always #2 clk = ~clk;

    queue_manager UUT (
        .clk             (clk),
        .rst             (rst),
        .in_queue_id     (in_queue_id),
        .in_size         (in_size),
        .in_pass_through (in_pass_through),
        .in_meta         (in_meta),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .out_head        (out_head),
        .out_tail        (out_tail),
        .out_buf_addr    (out_buf_addr),
        .out_drop        (out_drop),
        .out_meta        (out_meta),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .cfg_wr_en       (cfg_wr_en),
        .cfg_sel         (cfg_sel),
        .cfg_queue       (cfg_queue),
        .cfg_data        (cfg_data),
        .rb_size         (rb_size),
        .full_cnt        (full_cnt)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers.
    //////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[14:0], stim_lfsr[0]};
        end
    endtask

    task automatic check(input string what, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // Size zero in the table means a random size of 1 to 16 flits.
    task automatic add_pkt(input queue_id_t q, input pkt_size_t size, input logic pt,
                           input logic [1:0] expect_drop);
        logic [15:0] v;
        stim_tbl[tbl_len] = '0;
        stim_tbl[tbl_len].op = OP_PKT;
        stim_tbl[tbl_len].queue = q;
        stim_tbl[tbl_len].pt = pt;
        stim_tbl[tbl_len].expect_drop = expect_drop;
        if (size == '0) begin
            draw_bits(4, v);
            size = pkt_size_t'(v[3:0]) + 7'd1;
        end
        stim_tbl[tbl_len].size = size;
        tbl_len++;
    endtask

    task automatic add_cfg(input table_sel_t sel, input queue_id_t q, input buf_addr_t data);
        stim_tbl[tbl_len] = '0;
        stim_tbl[tbl_len].op = OP_CFG;
        stim_tbl[tbl_len].sel = sel;
        stim_tbl[tbl_len].queue = q;
        stim_tbl[tbl_len].data = data;
        tbl_len++;
    endtask

    task automatic config_queue(input queue_id_t q, input buf_addr_t head,
                                input buf_addr_t tail, input buf_addr_t addr);
        add_cfg(TABLE_HEAD, q, head);
        add_cfg(TABLE_TAIL, q, tail);
        add_cfg(TABLE_ADDR, q, addr);
    endtask

    task automatic build_table();
        logic [15:0] v;
        // Queue 0 starts near the top of the ring so its tail wraps.
        config_queue(4'd0, 32'd50, 32'd60, 32'h1000_0000);
        config_queue(4'd1, 32'd0, 32'd0, 32'h2000_0040);
        config_queue(4'd2, 32'd5, 32'd60, 32'h3000_0080);
        config_queue(4'd3, 32'd0, 32'd0, 32'h0000_0000);
        config_queue(4'd4, 32'd10, 32'd20, 32'h4000_00c0);
        add_pkt(4'd0, 7'd8, 1'b0, EXP_KEEP);
        add_pkt(4'd0, 7'd0, 1'b0, EXP_KEEP);
        add_pkt(4'd0, 7'd0, 1'b0, EXP_KEEP);
        // Back to back on one queue, then alternating queues.
        for (int i = 0; i < 3; i++) begin
            add_pkt(4'd1, 7'd0, 1'b0, EXP_KEEP);
        end
        for (int i = 0; i < 8; i++) begin
            add_pkt(queue_id_t'(i % 2), 7'd0, 1'b0, EXP_ANY);
        end
        // Queue 2 has 8 free slots.
        add_pkt(4'd2, 7'd12, 1'b0, EXP_DROP);
        add_pkt(4'd2, 7'd5, 1'b0, EXP_KEEP);
        add_pkt(4'd2, 7'd5, 1'b0, EXP_DROP);
        // Queue 4 has 53 free slots.
        add_pkt(4'd4, 7'd60, 1'b1, EXP_KEEP);
        add_pkt(4'd4, 7'd10, 1'b0, EXP_KEEP);
        // Queue 3 has no buffer address.
        add_pkt(4'd3, 7'd4, 1'b0, EXP_DROP);
        add_pkt(4'd3, 7'd4, 1'b1, EXP_DROP);
        add_pkt(4'd3, 7'd64, 1'b0, EXP_DROP);
        add_cfg(TABLE_TAIL, 4'd2, 32'd5);
        add_pkt(4'd2, 7'd20, 1'b0, EXP_KEEP);
        // Long output stall, then random output ready.
        stim_tbl[tbl_len] = '0;
        stim_tbl[tbl_len].op = OP_HOLD;
        stim_tbl[tbl_len].data = 32'd150;
        tbl_len++;
        for (int i = 0; i < 40; i++) begin
            draw_bits(2, v);
            add_pkt((v[1:0] == 2'd3) ? 4'd4 : queue_id_t'(v[1:0]), 7'd0, 1'b0, EXP_ANY);
        end
    endtask

    // The reference model is applied in input order.
    task automatic model_packet(input stim_t e, input meta_t meta);
        ring_ptr_t free_slots;
        logic      full;
        logic      drop;
        free_slots = (m_head[e.queue] - m_tail[e.queue] - 12'd1) & RING_MASK;
        full = (free_slots < ring_ptr_t'(e.size)) && !e.pt;
        drop = full || (m_addr[e.queue] == '0);
        exp_head[exp_wr] = m_head[e.queue];
        exp_tail[exp_wr] = m_tail[e.queue];
        exp_addr[exp_wr] = m_addr[e.queue];
        exp_drop[exp_wr] = drop;
        exp_meta[exp_wr] = meta;
        exp_wr++;
        if (full) begin
            m_full++;
        end
        if (!drop && !e.pt) begin
            m_tail[e.queue] = (m_tail[e.queue] + ring_ptr_t'(e.size)) & RING_MASK;
        end
        if (e.expect_drop != EXP_ANY) begin
            check("model drop", 64'(drop), 64'(e.expect_drop == EXP_DROP));
        end
    endtask

    task automatic send_packet(input int idx);
        @(negedge clk);
        in_queue_id = stim_tbl[idx].queue;
        in_size = stim_tbl[idx].size;
        in_pass_through = stim_tbl[idx].pt;
        in_meta = meta_t'(idx);
        in_valid = 1'b1;
        model_packet(stim_tbl[idx], meta_t'(idx));
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic host_write(input stim_t e);
        @(negedge clk);
        cfg_wr_en = 1'b1;
        cfg_sel = e.sel;
        cfg_queue = e.queue;
        cfg_data = e.data;
        case (e.sel)
            TABLE_HEAD: m_head[e.queue] = ring_ptr_t'(e.data);
            TABLE_TAIL: m_tail[e.queue] = ring_ptr_t'(e.data);
            default:    m_addr[e.queue] = e.data;
        endcase
        @(negedge clk);
        cfg_wr_en = 1'b0;
    endtask

    task automatic idle_input();
        if (in_valid) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output side.
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        holding = (cycle < hold_end);
        if (holding) begin
            out_ready = 1'b0;
        end else if (random_ready) begin
            ready_lfsr = lfsr_step(ready_lfsr);
            out_ready = ready_lfsr[0];
        end else begin
            out_ready = 1'b1;
        end
        cycle = cycle + 1;
    end

    always @(posedge clk) begin
        if (holding && !in_ready) begin
            saw_stall = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_rd == exp_wr) begin
                $display("Error at %0t: the DUT sent an output that was not expected", $time);
                $display("Simulation failed");
                $fatal(1, "unexpected output");
            end else begin
                check("out_head", 64'(out_head), 64'(exp_head[exp_rd]));
                check("out_tail", 64'(out_tail), 64'(exp_tail[exp_rd]));
                check("out_buf_addr", 64'(out_buf_addr), 64'(exp_addr[exp_rd]));
                check("out_drop", 64'(out_drop), 64'(exp_drop[exp_rd]));
                check("out_meta", 64'(out_meta), 64'(exp_meta[exp_rd]));
                exp_rd = exp_rd + 1;
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (tbl_len * 40 + 1000) @(posedge clk);
        $display("Error: the run timed out before all outputs arrived");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence.
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst = 1'b1;
        in_queue_id = '0;
        in_size = '0;
        in_pass_through = 1'b0;
        in_meta = '0;
        in_valid = 1'b0;
        cfg_wr_en = 1'b0;
        cfg_sel = TABLE_HEAD;
        cfg_queue = '0;
        cfg_data = '0;
        rb_size = 13'd64;
        hold_end = 0;
        random_ready = 1'b0;
        stim_lfsr = 16'd47;
        tbl_len = 0;
        exp_wr = 0;
        m_full = '0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < tbl_len; i++) begin
            case (stim_tbl[i].op)
                OP_PKT: begin
                    send_packet(i);
                end
                OP_CFG: begin
                    // Tables are only written while the pipeline is empty.
                    idle_input();
                    wait (exp_rd == exp_wr);
                    host_write(stim_tbl[i]);
                end
                default: begin
                    idle_input();
                    @(posedge clk);
                    hold_end = cycle + int'(stim_tbl[i].data);
                    random_ready = 1'b1;
                end
            endcase
        end

        idle_input();
        wait (exp_rd == exp_wr);
        // Nothing may be left in the output FIFO once every expected item is out.
        @(negedge clk);
        check("out_valid after drain", 64'(out_valid), 64'(1'b0));
        check("full_cnt", 64'(full_cnt), 64'(m_full));
        if (!saw_stall) begin
            $display("Error: in_ready never fell while out_ready was held low");
            $display("Simulation failed");
            $fatal(1, "no input back-pressure");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: all.f
+incdir+logic
logic/qm_pkg.sv
logic/qm_if.sv
logic/sync_fifo.sv
logic/queue_table.sv
logic/state_fetch.sv
logic/ring_update.sv
logic/queue_manager.sv
sim/tb_queue_manager.sv

// File: Makefile
# Verilator build and run for the queue manager testbench.

VERILATOR  ?= verilator
TOP        ?= tb_queue_manager
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exits with a failing status when the testbench stops on $$fatal.
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
